// File: verilog/ps2_pkg.sv
/*
  PS/2 wire protocol definitions shared by the mouse receiver.
  Covers the serial frame layout, the three-frame packet and the status byte bits.
*/
`default_nettype none

package ps2_pkg;

  // ------------------------------
  // frame and packet sizes
  // ------------------------------

  // one serial byte is start, eight data bits, odd parity and stop
  localparam int FRAME_BITS = 11;
  localparam int DATA_BITS = 8;

  // a movement packet is the status byte followed by the X and Y bytes
  localparam int PACKET_FRAMES = 3;
  localparam int PACKET_BITS = FRAME_BITS * PACKET_FRAMES;

  // ------------------------------
  // status byte bit positions
  // ------------------------------

  // overflow bits and the middle button are present on the wire but not decoded
  localparam int STATUS_LEFT = 0;
  localparam int STATUS_RIGHT = 1;
  localparam int STATUS_X_SIGN = 4;
  localparam int STATUS_Y_SIGN = 5;

  // one frame as it sits in the receive shift register
  // data goes out LSB first so data[0] lands right above the start bit
  typedef struct packed {
    logic                 stop;
    logic                 parity;
    logic [DATA_BITS-1:0] data;
    logic                 start;
  } ps2_frame_t;

  // the receiver shifts bits in at the MSB end through raw
  // the checks and the decode read the same word as frames
  // frame 0 is the status byte, frame 1 holds X and frame 2 holds Y
  typedef union packed {
    logic [PACKET_BITS-1:0]                raw;
    ps2_frame_t [PACKET_FRAMES-1:0]        frame;
  } ps2_packet_u;

endpackage

`default_nettype wire

// File: verilog/mouse_pkg.sv
/*
  Pointer side definitions for the mouse front end.
  Holds the cursor coordinate type and the signed movement increment type.
*/
`default_nettype none

package mouse_pkg;

  // width of one absolute cursor coordinate
  localparam int COORD_BITS = 12;

  // a PS/2 increment is a sign bit from the status byte plus eight magnitude bits
  localparam int DELTA_BITS = 9;

  // unsigned cursor position, clamped by the tracker
  typedef logic [COORD_BITS-1:0] coord_t;

  // two's complement increment, range -256..255
  typedef logic signed [DELTA_BITS-1:0] delta_t;

endpackage

`default_nettype wire

// File: verilog/mouse_report_if.sv
/*
  Carries one decoded movement report from the packet receiver to the tracker.
  report_valid is a single cycle strobe and the other fields only count in that cycle.
*/
`timescale 1ns/10ps
`default_nettype none

interface mouse_report_if;

  // strobe for one good packet, there is no back-pressure
  logic report_valid;

  // signed increments straight from the packet
  mouse_pkg::delta_t dx;
  mouse_pkg::delta_t dy;

  // button state from the status byte
  logic left;
  logic right;

  // the receiver drives every field
  modport source (output report_valid, output dx, output dy, output left, output right);

  // the tracker only reads
  modport sink (input report_valid, input dx, input dy, input left, input right);

endinterface

`default_nettype wire

// File: verilog/ps2_line_filter.sv
/*
  Synchronizes the PS/2 clock and data lines into the system clock domain.
  Turns the mouse clock into single cycle fall and rise pulses with bounce removed.
*/
`timescale 1ns/10ps
`default_nettype none

module ps2_line_filter #(
  parameter int DEBOUNCE_CYCLES = 246
) (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic fall_pulse,
  output logic rise_pulse,
  output logic data_sync
);

  // counter has to reach DEBOUNCE_CYCLES-1, one extra bit keeps small values legal
  localparam int DEB_W = $clog2(DEBOUNCE_CYCLES + 1);

  // four phase clock tracker encodings
  localparam logic [1:0] ST_HIGH = 2'd0;
  localparam logic [1:0] ST_FALL_WAIT = 2'd1;
  localparam logic [1:0] ST_LOW = 2'd2;
  localparam logic [1:0] ST_RISE_WAIT = 2'd3;

  // bit 1 is the mouse clock and bit 0 the data line
  logic [1:0] sync_stage1;
  logic [1:0] sync_stage2;
  logic clk_sync;
  logic [1:0] state;
  logic [DEB_W-1:0] debounce_count;
  logic debounce_done;

  // ------------------------------
  // two flop synchronizer
  // ------------------------------

  // idle PS/2 lines are pulled high, so reset loads ones and no edge is seen
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sync_stage1 <= 2'b11;
      sync_stage2 <= 2'b11;
    end
    else
    begin
      sync_stage1 <= {ps2_clk, ps2_data};
      sync_stage2 <= sync_stage1;
    end
  end

  assign clk_sync = sync_stage2[1];
  assign data_sync = sync_stage2[0];

  // ------------------------------
  // edge detection and debounce
  // ------------------------------

  assign debounce_done = (debounce_count == DEB_W'(DEBOUNCE_CYCLES - 1));

  // a level change in a stable phase gives one registered pulse
  // the wait phases then ignore the line until the debounce count runs out
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_HIGH;
      fall_pulse <= 1'b0;
      rise_pulse <= 1'b0;
      debounce_count <= '0;
    end
    else
    begin
      fall_pulse <= 1'b0;
      rise_pulse <= 1'b0;
      case (state)
        ST_HIGH:
        begin
          debounce_count <= '0;
          if (!clk_sync)
          begin
            fall_pulse <= 1'b1;
            state <= ST_FALL_WAIT;
          end
        end
        ST_LOW:
        begin
          debounce_count <= '0;
          if (clk_sync)
          begin
            rise_pulse <= 1'b1;
            state <= ST_RISE_WAIT;
          end
        end
        default:
        begin
          // both wait phases count out the same window
          debounce_count <= debounce_count + 1'b1;
          if (debounce_done)
          begin
            state <= (state == ST_FALL_WAIT) ? ST_LOW : ST_HIGH;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/ps2_packet_receiver.sv
/*
  Collects the 33 bits of a PS/2 mouse packet and checks every frame.
  A watchdog closes the packet after a quiet gap and a good one leaves as one report strobe.
*/
`timescale 1ns/10ps
`default_nettype none

module ps2_packet_receiver #(
  parameter int WATCHDOG_CYCLES = 26000
) (
  input  logic clk,
  input  logic reset,
  input  logic fall_pulse,
  input  logic rise_pulse,
  input  logic data_sync,
  mouse_report_if.source report
);

  localparam int WD_W = $clog2(WATCHDOG_CYCLES + 1);
  localparam int COUNT_W = $clog2(ps2_pkg::PACKET_BITS + 1);

  // receive FSM encodings
  localparam logic [1:0] ST_WAIT = 2'd0;
  localparam logic [1:0] ST_GATHER = 2'd1;
  localparam logic [1:0] ST_VERIFY = 2'd2;
  localparam logic [1:0] ST_USE = 2'd3;

  logic [1:0] state;
  logic [WD_W-1:0] watchdog_count;
  logic watchdog_done;
  logic [COUNT_W-1:0] bit_count;
  logic full_packet;
  ps2_pkg::ps2_packet_u packet;
  logic packet_good;

  // ------------------------------
  // watchdog
  // ------------------------------

  // restarts on any clock edge and parks once it has expired
  always_ff @(posedge clk)
  begin
    if (reset || fall_pulse || rise_pulse)
      watchdog_count <= '0;
    else if (!watchdog_done)
      watchdog_count <= watchdog_count + 1'b1;
  end

  assign watchdog_done = (watchdog_count == WD_W'(WATCHDOG_CYCLES - 1));

  // ------------------------------
  // bit counter and shift register
  // ------------------------------

  // the counter saturates so a long burst of stray edges cannot wrap back to 33
  always_ff @(posedge clk)
  begin
    if (reset)
      bit_count <= '0;
    else if (fall_pulse)
    begin
      if (bit_count != '1)
        bit_count <= bit_count + 1'b1;
    end
    else if (watchdog_done)
      bit_count <= '0;
  end

  assign full_packet = (bit_count == COUNT_W'(ps2_pkg::PACKET_BITS));

  // data is sampled on the falling mouse clock and enters at the top
  // after 33 shifts the first start bit sits at bit 0
  always_ff @(posedge clk)
  begin
    if (reset)
      packet.raw <= '0;
    else if (fall_pulse)
      packet.raw <= {data_sync, packet.raw[ps2_pkg::PACKET_BITS-1:1]};
  end

  // ------------------------------
  // frame checks
  // ------------------------------

  // every frame needs start low, stop high and odd parity over data plus parity
  always_comb
  begin
    packet_good = 1'b1;
    for (int i = 0; i < ps2_pkg::PACKET_FRAMES; i++)
    begin
      if (packet.frame[i].start || !packet.frame[i].stop)
        packet_good = 1'b0;
      if (!(^{packet.frame[i].data, packet.frame[i].parity}))
        packet_good = 1'b0;
    end
  end

  // ------------------------------
  // receive FSM
  // ------------------------------

  // expiry with a full count goes to verify, anything short is dropped
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ST_WAIT;
    else
    begin
      case (state)
        ST_WAIT:
        begin
          if (fall_pulse)
            state <= ST_GATHER;
        end
        ST_GATHER:
        begin
          if (watchdog_done)
            state <= full_packet ? ST_VERIFY : ST_WAIT;
        end
        ST_VERIFY:
          state <= packet_good ? ST_USE : ST_WAIT;
        default:
          state <= ST_WAIT;
      endcase
    end
  end

  // report fields come straight out of the frame view of the shift register
  assign report.report_valid = (state == ST_USE);
  assign report.dx = {packet.frame[0].data[ps2_pkg::STATUS_X_SIGN], packet.frame[1].data};
  assign report.dy = {packet.frame[0].data[ps2_pkg::STATUS_Y_SIGN], packet.frame[2].data};
  assign report.left = packet.frame[0].data[ps2_pkg::STATUS_LEFT];
  assign report.right = packet.frame[0].data[ps2_pkg::STATUS_RIGHT];

endmodule

`default_nettype wire

// File: verilog/mouse_position_tracker.sv
/*
  Keeps the absolute cursor position and the button state from mouse reports.
  Position is clamped to 0..MAX_X and 0..MAX_Y, with Y growing as the mouse moves down.
*/
`timescale 1ns/10ps
`default_nettype none

module mouse_position_tracker #(
  parameter int MAX_X = 1023,
  parameter int MAX_Y = 767
) (
  input  logic clk,
  input  logic reset,
  mouse_report_if.sink report,
  output mouse_pkg::coord_t mx,
  output mouse_pkg::coord_t my,
  output logic left_button,
  output logic right_button
);

  localparam int SIGN = mouse_pkg::DELTA_BITS - 1;
  localparam mouse_pkg::coord_t LIMIT_X = mouse_pkg::coord_t'(MAX_X);
  localparam mouse_pkg::coord_t LIMIT_Y = mouse_pkg::coord_t'(MAX_Y);

  // unsigned magnitudes, 9 bits hold 256 for the most negative increment
  logic [mouse_pkg::DELTA_BITS-1:0] mag_x;
  logic [mouse_pkg::DELTA_BITS-1:0] mag_y;
  mouse_pkg::coord_t next_x;
  mouse_pkg::coord_t next_y;

  // moves pos by step toward limit or toward zero and stops on the bound
  // the step is compared with the remaining distance so nothing wraps
  function automatic mouse_pkg::coord_t clamp_move(
    input mouse_pkg::coord_t pos,
    input logic [mouse_pkg::DELTA_BITS-1:0] mag,
    input logic toward_limit,
    input mouse_pkg::coord_t limit
  );
    mouse_pkg::coord_t step;
    mouse_pkg::coord_t result;
    step = mouse_pkg::coord_t'(mag);
    if (toward_limit)
      result = (step >= limit - pos) ? limit : pos + step;
    else
      result = (step >= pos) ? '0 : pos - step;
    return result;
  endfunction

  assign mag_x = report.dx[SIGN] ? (~report.dx + 9'd1) : report.dx;
  assign mag_y = report.dy[SIGN] ? (~report.dy + 9'd1) : report.dy;

  // positive dx heads right, negative dy heads down the screen
  assign next_x = clamp_move(mx, mag_x, !report.dx[SIGN], LIMIT_X);
  assign next_y = clamp_move(my, mag_y, report.dy[SIGN], LIMIT_Y);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mx <= '0;
      my <= '0;
      left_button <= 1'b0;
      right_button <= 1'b0;
    end
    else if (report.report_valid)
    begin
      mx <= next_x;
      my <= next_y;
      left_button <= report.left;
      right_button <= report.right;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ps2_mouse_xy.sv
/*
  Top level of the PS/2 mouse front end with plain ports.
  Connects line filter, packet receiver and position tracker and hands the parameters down.
*/
`timescale 1ns/10ps
`default_nettype none

module ps2_mouse_xy #(
  parameter int DEBOUNCE_CYCLES = 246,
  parameter int WATCHDOG_CYCLES = 26000,
  parameter int MAX_X = 1023,
  parameter int MAX_Y = 767
) (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,
  input  logic ps2_data,
  output mouse_pkg::coord_t mx,
  output mouse_pkg::coord_t my,
  output logic left_button,
  output logic right_button
);

  // filtered lines from the front of the chain
  logic fall_pulse;
  logic rise_pulse;
  logic data_sync;

  // decoded reports from receiver to tracker
  mouse_report_if report_bus ();

  ps2_line_filter #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) i_line_filter (
    .clk(clk),
    .reset(reset),
    .ps2_clk(ps2_clk),
    .ps2_data(ps2_data),
    .fall_pulse(fall_pulse),
    .rise_pulse(rise_pulse),
    .data_sync(data_sync)
  );

  ps2_packet_receiver #(
    .WATCHDOG_CYCLES(WATCHDOG_CYCLES)
  ) i_packet_receiver (
    .clk(clk),
    .reset(reset),
    .fall_pulse(fall_pulse),
    .rise_pulse(rise_pulse),
    .data_sync(data_sync),
    .report(report_bus.source)
  );

  mouse_position_tracker #(
    .MAX_X(MAX_X),
    .MAX_Y(MAX_Y)
  ) i_position_tracker (
    .clk(clk),
    .reset(reset),
    .report(report_bus.sink),
    .mx(mx),
    .my(my),
    .left_button(left_button),
    .right_button(right_button)
  );

endmodule

`default_nettype wire

// File: sim/mouse_checker.sv
/*
  Scoreboard for the PS/2 mouse testbench.
  Takes one packet summary per packet, predicts cursor and buttons and compares the DUT outputs.
*/
`timescale 1ns/10ps
`default_nettype none

module mouse_checker #(
  parameter int WATCHDOG_CYCLES = 60,
  parameter int MAX_X = 300,
  parameter int MAX_Y = 200
) (
  input  logic clk,
  input  logic reset,
  input  mouse_pkg::coord_t mx,
  input  mouse_pkg::coord_t my,
  input  logic left_button,
  input  logic right_button,
  input  logic pkt_done,
  input  mouse_pkg::delta_t pkt_dx,
  input  mouse_pkg::delta_t pkt_dy,
  input  logic pkt_left,
  input  logic pkt_right,
  input  logic pkt_good,
  output logic checking,
  output int value_errors,
  output int timeout_errors
);

  // a report is due about WATCHDOG_CYCLES after the last mouse clock edge
  // the extra 100 cycles are margin for the filter and receiver pipeline
  localparam int WINDOW_CYCLES = WATCHDOG_CYCLES + 100;
  localparam int RESET_LIMIT = 100;

  // expected DUT state after every packet seen so far
  int exp_x;
  int exp_y;
  logic exp_left;
  logic exp_right;

  // the cursor moves by delta and stops on 0 or on limit
  function automatic int clamp_axis(input int pos, input int delta, input int limit);
    int moved;
    moved = pos + delta;
    if (moved < 0)
      moved = 0;
    else if (moved > limit)
      moved = limit;
    return moved;
  endfunction

  function automatic logic outputs_match();
    return (int'(mx) == exp_x) && (int'(my) == exp_y)
      && (left_button == exp_left) && (right_button == exp_right);
  endfunction

  // one FAIL line for every output that is off
  task automatic compare_outputs();
    if (int'(mx) != exp_x)
    begin
      $display("FAIL t=%0t mx expected %0d got %0d", $time, exp_x, mx);
      value_errors++;
    end
    if (int'(my) != exp_y)
    begin
      $display("FAIL t=%0t my expected %0d got %0d", $time, exp_y, my);
      value_errors++;
    end
    if (left_button != exp_left)
    begin
      $display("FAIL t=%0t left_button expected %0d got %0d", $time, exp_left, left_button);
      value_errors++;
    end
    if (right_button != exp_right)
    begin
      $display("FAIL t=%0t right_button expected %0d got %0d", $time, exp_right, right_button);
      value_errors++;
    end
  endtask

  // ------------------------------
  // per packet check
  // ------------------------------

  task automatic check_packet();
    int next_x;
    int next_y;
    int waited;
    logic change_due;
    checking = 1'b1;
    change_due = 1'b0;
    if (pkt_good)
    begin
      next_x = clamp_axis(exp_x, int'(pkt_dx), MAX_X);
      // downward mouse motion raises the video Y value
      next_y = clamp_axis(exp_y, -int'(pkt_dy), MAX_Y);
      change_due = (next_x != exp_x) || (next_y != exp_y)
        || (pkt_left != exp_left) || (pkt_right != exp_right);
      exp_x = next_x;
      exp_y = next_y;
      exp_left = pkt_left;
      exp_right = pkt_right;
    end
    waited = 0;
    @(negedge clk);
    if (change_due)
    begin
      while (!outputs_match() && waited < WINDOW_CYCLES)
      begin
        @(negedge clk);
        waited++;
      end
      if (!outputs_match())
      begin
        $display("timeout: no position update within %0d cycles of a good packet",
          WINDOW_CYCLES);
        timeout_errors++;
      end
    end
    else
    begin
      // a dropped or no-op packet has to leave the outputs alone for the whole window
      while (outputs_match() && waited < WINDOW_CYCLES)
      begin
        @(negedge clk);
        waited++;
      end
    end
    compare_outputs();
    checking = 1'b0;
  endtask

  // outputs are sampled on the falling clock edge, summaries on the rising one
  initial
  begin
    int waited;
    checking = 1'b0;
    value_errors = 0;
    timeout_errors = 0;
    exp_x = 0;
    exp_y = 0;
    exp_left = 1'b0;
    exp_right = 1'b0;
    waited = 0;
    while (reset !== 1'b0 && waited < RESET_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (reset !== 1'b0)
    begin
      $display("timeout: reset was never released");
      timeout_errors++;
    end
    // everything has to be zero before the first packet
    @(negedge clk);
    compare_outputs();
    forever
    begin
      @(posedge clk);
      if (pkt_done)
        check_packet();
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_ps2_mouse_xy.sv
/*
  Testbench for the PS/2 mouse front end.
  Plays a mouse that streams movement packets and lets mouse_checker judge the cursor outputs.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_ps2_mouse_xy;

  localparam int DEBOUNCE_CYCLES = 3;
  localparam int WATCHDOG_CYCLES = 60;
  localparam int MAX_X = 300;
  localparam int MAX_Y = 200;

  // device timing in system cycles
  localparam int HALF_BIT = 8;
  localparam int BYTE_GAP = 20;
  localparam int PACKET_IDLE = 120;
  localparam int CHECK_WAIT_LIMIT = 200;

  // which frame error a packet carries
  localparam int FAULT_NONE = 0;
  localparam int FAULT_PARITY = 1;
  localparam int FAULT_STOP = 2;

  logic clk;
  logic reset;
  logic ps2_clk;
  logic ps2_data;
  mouse_pkg::coord_t mx;
  mouse_pkg::coord_t my;
  logic left_button;
  logic right_button;

  // packet summary handed to the checker
  logic pkt_done;
  mouse_pkg::delta_t pkt_dx;
  mouse_pkg::delta_t pkt_dy;
  logic pkt_left;
  logic pkt_right;
  logic pkt_good;
  logic checking;
  int value_errors;
  int timeout_errors;

  // packets after which the checker never came back
  int stall_errors;

  logic [31:0] lfsr;

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ps2_mouse_xy #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
    .WATCHDOG_CYCLES(WATCHDOG_CYCLES),
    .MAX_X(MAX_X),
    .MAX_Y(MAX_Y)
  ) i_ps2_mouse_xy (
    .clk(clk),
    .reset(reset),
    .ps2_clk(ps2_clk),
    .ps2_data(ps2_data),
    .mx(mx),
    .my(my),
    .left_button(left_button),
    .right_button(right_button)
  );

  mouse_checker #(
    .WATCHDOG_CYCLES(WATCHDOG_CYCLES),
    .MAX_X(MAX_X),
    .MAX_Y(MAX_Y)
  ) i_mouse_checker (
    .clk(clk),
    .reset(reset),
    .mx(mx),
    .my(my),
    .left_button(left_button),
    .right_button(right_button),
    .pkt_done(pkt_done),
    .pkt_dx(pkt_dx),
    .pkt_dy(pkt_dy),
    .pkt_left(pkt_left),
    .pkt_right(pkt_right),
    .pkt_good(pkt_good),
    .checking(checking),
    .value_errors(value_errors),
    .timeout_errors(timeout_errors)
  );

  // ------------------------------
  // random source
  // ------------------------------

  // 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // one LFSR step for every bit taken
  task automatic take_random(input int count, output logic [8:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr = lfsr_step(lfsr);
      value = {value[7:0], lfsr[0]};
    end
  endtask

  // ------------------------------
  // PS/2 device model
  // ------------------------------

  task automatic wait_cycles(input int count);
    repeat (count) @(negedge clk);
  endtask

  // data settles while the mouse clock is high and the host samples on the fall
  // a glitch is one system cycle wide, right after each real edge
  task automatic drive_bit(input logic value, input logic glitch);
    ps2_data = value;
    wait_cycles(HALF_BIT);
    ps2_clk = 1'b0;
    if (glitch)
    begin
      wait_cycles(1);
      ps2_clk = 1'b1;
      wait_cycles(1);
      ps2_clk = 1'b0;
      wait_cycles(HALF_BIT - 2);
    end
    else
      wait_cycles(HALF_BIT);
    ps2_clk = 1'b1;
    if (glitch)
    begin
      wait_cycles(1);
      ps2_clk = 1'b0;
      wait_cycles(1);
      ps2_clk = 1'b1;
      wait_cycles(HALF_BIT - 2);
    end
    else
      wait_cycles(HALF_BIT);
  endtask

  // start, eight data bits LSB first, odd parity, stop
  task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                            input logic bad_stop, input logic glitch);
    drive_bit(1'b0, glitch);
    for (int i = 0; i < 8; i++)
      drive_bit(data[i], glitch);
    drive_bit(~^data ^ bad_parity, glitch);
    drive_bit(!bad_stop, glitch);
    ps2_data = 1'b1;
  endtask

  // sends up to three frames, hands the summary over and waits for the verdict
  task automatic run_packet(input mouse_pkg::delta_t dx, input mouse_pkg::delta_t dy,
                            input logic left, input logic right, input int fault,
                            input int frames, input logic glitch);
    logic [7:0] bytes [3];
    int waited;
    // bit 3 of the status byte is always set by a real mouse
    bytes[0] = {2'b00, dy[8], dx[8], 1'b1, 1'b0, right, left};
    bytes[1] = dx[7:0];
    bytes[2] = dy[7:0];
    for (int f = 0; f < frames; f++)
    begin
      if (f > 0)
        wait_cycles(BYTE_GAP);
      send_frame(bytes[f], (fault == FAULT_PARITY) && (f == 1),
                 (fault == FAULT_STOP) && (f == 2), glitch);
    end
    pkt_dx = dx;
    pkt_dy = dy;
    pkt_left = left;
    pkt_right = right;
    pkt_good = (fault == FAULT_NONE) && (frames == ps2_pkg::PACKET_FRAMES);
    pkt_done = 1'b1;
    wait_cycles(1);
    pkt_done = 1'b0;
    wait_cycles(PACKET_IDLE);
    waited = 0;
    while (checking && waited < CHECK_WAIT_LIMIT)
    begin
      wait_cycles(1);
      waited++;
    end
    if (checking)
    begin
      $display("timeout: checker still busy %0d cycles after the idle gap", CHECK_WAIT_LIMIT);
      stall_errors++;
    end
  endtask

  task automatic run_random_packet(input logic glitch);
    logic [8:0] dx_bits;
    logic [8:0] dy_bits;
    logic [8:0] left_bit;
    logic [8:0] right_bit;
    take_random(9, dx_bits);
    take_random(9, dy_bits);
    take_random(1, left_bit);
    take_random(1, right_bit);
    run_packet(dx_bits, dy_bits, left_bit[0], right_bit[0], FAULT_NONE,
               ps2_pkg::PACKET_FRAMES, glitch);
  endtask

  // ------------------------------
  // stimulus sequence
  // ------------------------------

  initial
  begin
    reset = 1'b1;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    pkt_done = 1'b0;
    pkt_dx = '0;
    pkt_dy = '0;
    pkt_left = 1'b0;
    pkt_right = 1'b0;
    pkt_good = 1'b0;
    stall_errors = 0;
    lfsr = 32'hea6a_7777;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // the checker looks at the reset state during this gap
    wait_cycles(10);
    for (int n = 0; n < 40; n++)
      run_random_packet(1'b0);
    // full scale pushes into the right and bottom edges, then back to the origin
    for (int n = 0; n < 3; n++)
      run_packet(9'h0ff, 9'h100, 1'b1, 1'b0, FAULT_NONE, ps2_pkg::PACKET_FRAMES, 1'b0);
    for (int n = 0; n < 3; n++)
      run_packet(9'h100, 9'h0ff, 1'b0, 1'b1, FAULT_NONE, ps2_pkg::PACKET_FRAMES, 1'b0);
    // move away from the bounds so a wrongly accepted packet would show
    run_packet(9'd100, -9'sd80, 1'b0, 1'b0, FAULT_NONE, ps2_pkg::PACKET_FRAMES, 1'b0);
    run_packet(9'd50, -9'sd50, 1'b1, 1'b1, FAULT_PARITY, ps2_pkg::PACKET_FRAMES, 1'b0);
    run_packet(-9'sd40, 9'd30, 1'b1, 1'b0, FAULT_STOP, ps2_pkg::PACKET_FRAMES, 1'b0);
    // a two frame burst is dropped and the next packet must line up again
    run_packet(9'd40, -9'sd30, 1'b0, 1'b1, FAULT_NONE, 2, 1'b0);
    run_packet(-9'sd20, 9'd10, 1'b1, 1'b0, FAULT_NONE, ps2_pkg::PACKET_FRAMES, 1'b0);
    // bounce on every mouse clock edge
    run_random_packet(1'b1);
    run_random_packet(1'b1);
    wait_cycles(20);
    $display("errors: %0d value mismatches, %0d timeouts", value_errors,
             timeout_errors + stall_errors);
    if (value_errors == 0 && timeout_errors == 0 && stall_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/ps2_pkg.sv
verilog/mouse_pkg.sv
verilog/mouse_report_if.sv
verilog/ps2_line_filter.sv
verilog/ps2_packet_receiver.sv
verilog/mouse_position_tracker.sv
verilog/ps2_mouse_xy.sv
sim/mouse_checker.sv
sim/tb_ps2_mouse_xy.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the PS/2 mouse testbench with Verilator and runs it.
# The exit status is zero only when the pass message shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_ps2_mouse_xy \
  -f compile.f \
  --Mdir obj_dir \
  -o tb_ps2_mouse_xy

output="$(./obj_dir/tb_ps2_mouse_xy)"
echo "$output"

if grep -q "Testbench passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
